// ==== dnc_gate_unit.f ====
ntm_math_pkg.sv
dnc_config_pkg.sv
logistic_if.sv
ntm_scalar_logistic_function.sv
dnc_allocation_gate.sv
dnc_free_gate_vector.sv
dnc_gate_unit.sv
dnc_gate_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the gate stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module dnc_gate_unit_tb -f dnc_gate_unit.f \
  --Mdir obj_dir -o sim_gate_unit > build.log 2>&1 \
  && ./obj_dir/sim_gate_unit > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log

grep -q "^SIMULATION PASSED$" sim.log \
  && echo "Result: pass" \
  || { echo "Result: fail"; exit 1; }

// ==== dnc_gate_unit_tb.sv ====
/*
 * Testbench for the gate stage top level
 * Stimulus table with expected values from a logistic reference model
 * Allocation gate, free-gate vector, concurrent runs and reset state
 */
`timescale 1ns/10ps
`default_nettype none

module dnc_gate_unit_tb
  import ntm_math_pkg::*;
  import dnc_config_pkg::*;
();

  ////////////////////
  // Constants
  ////////////////////

  localparam int ONE     = 1 << FRAC_BITS;
  localparam int NFIX    = 18;
  localparam int NRAND   = 12;
  localparam int NTAB    = NFIX + NRAND;
  localparam int GA_LAT  = 3;
  localparam int FG_LAT  = 4 * R_HEADS + 1;
  localparam int TIMEOUT = 40;

  ////////////////////
  // Signals
  ////////////////////

  logic      clk;
  logic      rst_n;
  logic      ga_start;
  fixed_t    ga_in;
  logic      ga_ready;
  fixed_t    ga_out;
  logic      fg_start;
  gate_vec_t fg_in;
  logic      fg_ready;
  gate_vec_t fg_out;

  int errors;
  int timeouts;

  // Stimulus, expected value and observed value per entry
  fixed_t stim [NTAB];
  fixed_t expv [NTAB];
  fixed_t got  [NTAB];

  dnc_gate_unit UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .ga_start (ga_start),
    .ga_in    (ga_in),
    .ga_ready (ga_ready),
    .ga_out   (ga_out),
    .fg_start (fg_start),
    .fg_in    (fg_in),
    .fg_ready (fg_ready),
    .fg_out   (fg_out)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Piecewise-linear logistic on the magnitude, mirrored for negatives
  function automatic fixed_t logistic_ref(input fixed_t x);
    longint a;
    longint r;
    a = (x < 0) ? -longint'(x) : longint'(x);
    if (a >= 5 * ONE) begin
      r = ONE;
    end else if (a >= 19 * ONE / 8) begin
      r = a / 32 + 27 * ONE / 32;
    end else if (a >= ONE) begin
      r = a / 8 + 5 * ONE / 8;
    end else begin
      r = a / 4 + ONE / 2;
    end
    if (x < 0) begin
      r = ONE - r;
    end
    return fixed_t'(r);
  endfunction

  ////////////////////
  // Check helpers
  ////////////////////

  task automatic check_value(input string what, input fixed_t obs, input fixed_t exp_v);
    assert (obs === exp_v) else begin
      errors++;
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, obs, exp_v);
    end
  endtask

  task automatic check_count(input string what, input int obs, input int exp_v);
    assert (obs == exp_v) else begin
      errors++;
      $display("[FAIL] %0t: %s took %0d cycles, expected %0d", $time, what, obs, exp_v);
    end
  endtask

  // Counts cycles since start, sampling at the falling edge
  task automatic wait_for_ready(input bit free_path, input string name, output int cyc);
    cyc = 1;
    @(negedge clk);
    while (!(free_path ? fg_ready : ga_ready) && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (!(free_path ? fg_ready : ga_ready)) begin
      timeouts++;
      $display("ERROR: the %s gave no ready within %0d cycles", name, TIMEOUT);
    end
  endtask

  ////////////////////
  // Stimulus tasks
  ////////////////////

  // One allocation gate evaluation, result returned in y
  task automatic run_alloc(input fixed_t x, output fixed_t y);
    int cyc;
    @(posedge clk);
    ga_start <= 1'b1;
    ga_in    <= x;
    @(posedge clk);
    ga_start <= 1'b0;
    wait_for_ready(1'b0, "allocation gate", cyc);
    check_count("ga_ready", cyc, GA_LAT);
    y = ga_out;
    // Result stays after the ready pulse
    @(negedge clk);
    check_value("ga_out after ready", ga_out, y);
  endtask

  // One free-gate vector evaluation, every head checked
  task automatic run_free(input gate_vec_t v);
    int cyc;
    @(posedge clk);
    fg_start <= 1'b1;
    fg_in    <= v;
    @(posedge clk);
    fg_start <= 1'b0;
    wait_for_ready(1'b1, "free-gate vector", cyc);
    check_count("fg_ready", cyc, FG_LAT);
    for (int k = 0; k < R_HEADS; k++) begin
      check_value($sformatf("fg_out[%0d]", k), fg_out[k], logistic_ref(v[k]));
    end
  endtask

  // Edges, signs, saturation, then random x and -x pairs
  task automatic build_table();
    int r;
    stim[0]  = '0;
    stim[1]  = fixed_t'(ONE / 2);
    stim[2]  = -fixed_t'(ONE / 2);
    stim[3]  = fixed_t'(ONE - 1);
    stim[4]  = -fixed_t'(ONE - 1);
    stim[5]  = fixed_t'(ONE);
    stim[6]  = -fixed_t'(ONE);
    stim[7]  = fixed_t'(19 * ONE / 8 - 1);
    stim[8]  = fixed_t'(19 * ONE / 8);
    stim[9]  = -fixed_t'(19 * ONE / 8);
    stim[10] = fixed_t'(5 * ONE - 1);
    stim[11] = -fixed_t'(5 * ONE - 1);
    stim[12] = fixed_t'(5 * ONE);
    stim[13] = -fixed_t'(5 * ONE);
    stim[14] = fixed_t'(6 * ONE);
    stim[15] = -fixed_t'(6 * ONE);
    stim[16] = 32'h7fff_ffff;
    stim[17] = 32'h8000_0000;
    for (int i = NFIX; i < NTAB; i += 2) begin
      // Range -8 .. +8
      r = int'($urandom % 32'd1048576) - 524288;
      stim[i]     = fixed_t'(r);
      stim[i + 1] = -fixed_t'(r);
    end
    for (int i = 0; i < NTAB; i++) begin
      expv[i] = logistic_ref(stim[i]);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    gate_vec_t v;
    fixed_t    y;
    int        n;
    errors   = 0;
    timeouts = 0;
    rst_n    = 1'b0;
    ga_start = 1'b0;
    ga_in    = '0;
    fg_start = 1'b0;
    fg_in    = '0;
    void'($urandom(32'hccb0b1d7));
    build_table();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    // Reset state
    check_value("ga_ready after reset", fixed_t'(ga_ready), '0);
    check_value("fg_ready after reset", fixed_t'(fg_ready), '0);
    check_value("ga_out after reset", ga_out, '0);
    for (int k = 0; k < R_HEADS; k++) begin
      check_value("fg_out after reset", fg_out[k], '0);
    end

    // Table through the allocation gate, saturation on the side
    for (int i = 0; i < NTAB; i++) begin
      run_alloc(stim[i], got[i]);
      check_value($sformatf("ga_out for %h", stim[i]), got[i], expv[i]);
      if (stim[i] >= fixed_t'(5 * ONE)) begin
        check_value("ga_out saturated high", got[i], fixed_t'(ONE));
      end else if (stim[i] <= -fixed_t'(5 * ONE)) begin
        check_value("ga_out saturated low", got[i], '0);
      end
    end

    // sigmoid(x) + sigmoid(-x) = 1; most negative word has no mirror
    for (int i = 0; i < NTAB; i++) begin
      for (int j = i; j < NTAB; j++) begin
        if (stim[j] == -stim[i] && stim[i] != 32'h8000_0000) begin
          check_value("symmetric pair sum", got[i] + got[j], fixed_t'(ONE));
        end
      end
    end

    // Table in vectors of R_HEADS
    for (int b = 0; b + R_HEADS <= NTAB; b += R_HEADS) begin
      for (int k = 0; k < R_HEADS; k++) begin
        v[k] = stim[b + k];
      end
      run_free(v);
    end

    // Both paths at once, ga_out held while the vector runs
    for (int k = 0; k < R_HEADS; k++) begin
      v[k] = stim[NTAB - 1 - k];
    end
    fork
      run_free(v);
      begin
        run_alloc(stim[8], y);
        check_value("ga_out concurrent", y, expv[8]);
        run_alloc(stim[19], y);
        check_value("ga_out concurrent", y, expv[19]);
        n = 0;
        while (!fg_ready && n < TIMEOUT) begin
          check_value("ga_out held during free gates", ga_out, expv[19]);
          @(negedge clk);
          n++;
        end
      end
    join

    $display("Closing count: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dnc_gate_unit.sv ====
/*
 * Gate stage top level
 * Allocation gate and free-gate vector, independent paths
 */
`timescale 1ns/10ps
`default_nettype none

module dnc_gate_unit
  import ntm_math_pkg::*;
  import dnc_config_pkg::*;
(
  // Global
  input  logic      clk,
  input  logic      rst_n,

  // Allocation gate
  input  logic      ga_start,
  input  fixed_t    ga_in,
  output logic      ga_ready,
  output fixed_t    ga_out,

  // Free gates, one per read head
  input  logic      fg_start,
  input  gate_vec_t fg_in,
  output logic      fg_ready,
  output gate_vec_t fg_out
);

  ////////////////////
  // Allocation gate
  ////////////////////

  // Own core, result after three cycles
  dnc_allocation_gate dnc_allocation_gate_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (ga_start),
    .ready  (ga_ready),
    .ga_in  (ga_in),
    .ga_out (ga_out)
  );

  ////////////////////
  // Free gates
  ////////////////////

  // Own core, heads in sequence
  dnc_free_gate_vector dnc_free_gate_vector_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (fg_start),
    .ready  (fg_ready),
    .fg_in  (fg_in),
    .fg_out (fg_out)
  );

endmodule

`default_nettype wire

// ==== dnc_free_gate_vector.sv ====
/*
 * Free gates of all read heads as f[k] = sigmoid(fg_in[k])
 * Heads go one after another through a shared logistic core
 * Result vector published at once after the last head
 */
`timescale 1ns/10ps
`default_nettype none

module dnc_free_gate_vector
  import ntm_math_pkg::*;
  import dnc_config_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  output logic      ready,
  input  gate_vec_t fg_in,
  output gate_vec_t fg_out
);

  ////////////////////
  // Signals
  ////////////////////

  logistic_if lg ();

  // Control
  logic      busy;
  logic      issue;
  head_idx_t head;
  logic      last_head;

  // Raw gates captured at start
  gate_vec_t raw_q;
  // Results collected so far
  gate_vec_t res_q;
  gate_vec_t res_next;

  ////////////////////
  // Head sequencing
  ////////////////////

  assign last_head = (head == head_idx_t'(R_HEADS - 1));

  // Head 0 goes one cycle after start and head k one cycle after ready of k-1
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      issue <= 1'b0;
      head  <= '0;
      ready <= 1'b0;
    end else begin
      issue <= 1'b0;
      ready <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        issue <= 1'b1;
        head  <= '0;
      end else if (lg.ready) begin
        if (last_head) begin
          // All heads done
          busy  <= 1'b0;
          ready <= 1'b1;
        end else begin
          head  <= head + 1'b1;
          issue <= 1'b1;
        end
      end
    end
  end

  // Current head to the core
  assign lg.start   = issue;
  assign lg.data_in = raw_q[head];

  ////////////////////
  // Result collection
  ////////////////////

  // Merge the arriving result into its slot
  always_comb begin
    res_next       = res_q;
    res_next[head] = lg.data_out;
  end

  always_ff @(posedge clk) begin
    if (start) begin
      raw_q <= fg_in;
    end
    if (lg.ready) begin
      res_q <= res_next;
    end
  end

  // Whole vector updates together with ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fg_out <= '0;
    end else if (lg.ready && last_head) begin
      fg_out <= res_next;
    end
  end

  // Shared logistic core
  ntm_scalar_logistic_function ntm_scalar_logistic_function_i (
    .clk   (clk),
    .rst_n (rst_n),
    .lg    (lg)
  );

  ////////////////////
  // Checks
  ////////////////////

  // Core answers only inside a run, with the counter on a real head
  a_head_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    lg.ready |-> busy && int'(head) < R_HEADS
  );

  a_no_start_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    start |-> !busy
  );

endmodule

`default_nettype wire

// ==== dnc_allocation_gate.sv ====
/*
 * Allocation gate, ga = sigmoid(ga_in)
 * Busy tracking and a held result around one logistic core
 */
`timescale 1ns/10ps
`default_nettype none

module dnc_allocation_gate
  import ntm_math_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   start,
  output logic   ready,
  input  fixed_t ga_in,
  output fixed_t ga_out
);

  ////////////////////
  // Signals
  ////////////////////

  logistic_if lg ();

  // Evaluation in progress
  logic   busy;
  // Last published gate value
  fixed_t ga_hold;

  ////////////////////
  // Body
  ////////////////////

  // Request goes straight to the core
  assign lg.start   = start;
  assign lg.data_in = ga_in;

  // Busy from start until the core answers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
    end else if (lg.ready) begin
      busy <= 1'b0;
    end
  end

  // Result register, zero until the first evaluation
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ga_hold <= '0;
    end else if (lg.ready) begin
      ga_hold <= lg.data_out;
    end
  end

  // New value shows with ready, held value otherwise
  assign ready  = lg.ready;
  assign ga_out = lg.ready ? lg.data_out : ga_hold;

  // Logistic core
  ntm_scalar_logistic_function ntm_scalar_logistic_function_i (
    .clk   (clk),
    .rst_n (rst_n),
    .lg    (lg)
  );

  ////////////////////
  // Checks
  ////////////////////

  // Back-to-back start allowed only in the cycle of ready
  a_no_start_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    start |-> (!busy || lg.ready)
  );

endmodule

`default_nettype wire

// ==== ntm_scalar_logistic_function.sv ====
/*
 * Fixed-point logistic core, shift-and-add segments
 * Three stages for magnitude and sign, segment select and mirror
 * One item in flight, ready three cycles after start
 */
`timescale 1ns/10ps
`default_nettype none

module ntm_scalar_logistic_function
  import ntm_math_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  logistic_if.core lg
);

  ////////////////////
  // Signals
  ////////////////////

  // Stage 1 keeps the magnitude unsigned
  // so the most negative input still reads as a large value
  logic                 s1_valid;
  logic                 s1_neg;
  logic [DATA_SIZE-1:0] s1_mag;

  // Stage 2 result for the magnitude
  logic   s2_valid;
  logic   s2_neg;
  fixed_t s2_val;

  // Stage 3 final result
  logic   s3_valid;
  fixed_t s3_val;

  // Segment value for the stage 1 magnitude
  fixed_t seg_val;

  ////////////////////
  // Valid tracking
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      s1_valid <= lg.start;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  // Piecewise-linear rule on the magnitude
  always_comb begin
    if (s1_mag >= $unsigned(LOG_BREAK_SAT)) begin
      seg_val = FX_ONE;
    end else if (s1_mag >= $unsigned(LOG_BREAK_HI)) begin
      // a/32 + 0.84375
      seg_val = $signed(s1_mag >> LOG_SHIFT_HI) + LOG_OFS_HI;
    end else if (s1_mag >= $unsigned(LOG_BREAK_LO)) begin
      // a/8 + 0.625
      seg_val = $signed(s1_mag >> LOG_SHIFT_MID) + LOG_OFS_MID;
    end else begin
      // a/4 + 0.5
      seg_val = $signed(s1_mag >> LOG_SHIFT_LO) + LOG_OFS_LO;
    end
  end

  // Stages load only with their valid and hold otherwise
  always_ff @(posedge clk) begin
    // Stage 1 takes sign and absolute value
    if (lg.start) begin
      s1_neg <= lg.data_in[DATA_SIZE-1];
      s1_mag <= lg.data_in[DATA_SIZE-1] ? DATA_SIZE'(-lg.data_in) : lg.data_in;
    end
    // Stage 2 selects the segment and does the shift-add
    if (s1_valid) begin
      s2_neg <= s1_neg;
      s2_val <= seg_val;
    end
    // Stage 3 mirrors negatives as 1 - sigmoid(a)
    if (s2_valid) begin
      s3_val <= s2_neg ? FX_ONE - s2_val : s2_val;
    end
  end

  assign lg.ready    = s3_valid;
  assign lg.data_out = s3_val;

  ////////////////////
  // Checks
  ////////////////////

  // Each completion has its request three cycles before and no other since
  a_ready_after_start: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(lg.ready) |-> $past(lg.start, 3) && !$past(lg.start, 2) && !$past(lg.start, 1)
  );

endmodule

`default_nettype wire

// ==== logistic_if.sv ====
/*
 * Start/ready link between a gate block and its logistic core
 * Client and core modports
 */
`timescale 1ns/10ps
`default_nettype none

interface logistic_if
  import ntm_math_pkg::*;
();

  // One-cycle request pulse, data_in valid with it
  logic   start;
  // One-cycle completion pulse
  logic   ready;
  fixed_t data_in;
  // Valid with ready, stable until the next ready
  fixed_t data_out;

  // Gate side
  modport client (
    output start,
    output data_in,
    input  ready,
    input  data_out
  );

  // Logistic core side
  modport core (
    input  start,
    input  data_in,
    output ready,
    output data_out
  );

endinterface

`default_nettype wire

// ==== dnc_config_pkg.sv ====
/*
 * Memory interface configuration
 * Read-head count, head index and free-gate vector types
 */
`default_nettype none

package dnc_config_pkg;

  import ntm_math_pkg::*;

  ////////////////////
  // Read heads
  ////////////////////

  // Number of read heads, one free gate each
  localparam int R_HEADS = 4;

  // Head counter, covers 0 .. R_HEADS-1
  typedef logic [$clog2(R_HEADS)-1:0] head_idx_t;

  // One fixed-point gate per head, head 0 in the low word
  typedef fixed_t [R_HEADS-1:0] gate_vec_t;

endpackage

`default_nettype wire

// ==== ntm_math_pkg.sv ====
/*
 * Fixed-point number format for the gate datapath
 * Logistic segment breakpoints, offsets and slope shifts
 */
`default_nettype none

package ntm_math_pkg;

  ////////////////////
  // Number format
  ////////////////////

  // Signed Q15.16 word
  localparam int DATA_SIZE = 32;
  localparam int FRAC_BITS = 16;

  typedef logic signed [DATA_SIZE-1:0] fixed_t;

  // Common constants
  localparam fixed_t FX_ONE  = fixed_t'(1 << FRAC_BITS);
  localparam fixed_t FX_HALF = fixed_t'(1 << (FRAC_BITS - 1));

  ////////////////////
  // Logistic segments
  ////////////////////

  // Magnitude bounds: 5.0, 2.375, 1.0
  localparam fixed_t LOG_BREAK_SAT = fixed_t'(5 << FRAC_BITS);
  localparam fixed_t LOG_BREAK_HI  = fixed_t'((19 << FRAC_BITS) / 8);
  localparam fixed_t LOG_BREAK_LO  = FX_ONE;

  // Segment offsets: 0.84375, 0.625, 0.5
  localparam fixed_t LOG_OFS_HI  = fixed_t'((27 << FRAC_BITS) / 32);
  localparam fixed_t LOG_OFS_MID = fixed_t'((5 << FRAC_BITS) / 8);
  localparam fixed_t LOG_OFS_LO  = FX_HALF;

  // Slopes 1/32, 1/8, 1/4 as right shifts
  localparam int LOG_SHIFT_HI  = 5;
  localparam int LOG_SHIFT_MID = 3;
  localparam int LOG_SHIFT_LO  = 2;

endpackage

`default_nettype wire
